//--- project.f
logic/video_pkg.sv
logic/line_wr_if.sv
logic/line_buffer.sv
logic/line_writer.sv
logic/line_reader.sv
logic/rgb_encoder.sv
logic/video_out_top.sv
verification/video_out_properties.sv
verification/video_out_tb.sv

//--- run.sh
#!/bin/sh
# Build the simulation with Verilator, run it, and pass only on the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module video_out_tb \
   -f project.f -Mdir obj_dir -o video_out_sim || exit 1
out=$(./obj_dir/video_out_sim)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1

//--- verification/video_out_tb.sv
`timescale 1ns/1ps

module video_out_tb;
   import video_pkg::*;

   localparam int ROWS        = 8;
   localparam int EN_TIMEOUT  = 16;    // Clocks to wait for one input enable.
   localparam int RUN_TIMEOUT = 4096;

   typedef struct packed {
      addr_t  len;
      color_t overlay;
      color_t base;
   } row_t;

   // Line length, overlay color (0 is off), first pixel color.
   row_t stim_table [ROWS] = '{
      {9'd16,  4'h0, 4'h1},
      {9'd20,  4'h0, 4'h0},
      {9'd24,  4'h5, 4'h3},
      {9'd40,  4'h0, 4'h7},
      {9'd36,  4'hC, 4'h0},
      {9'd64,  4'h0, 4'hF},
      {9'd60,  4'h0, 4'h2},
      {9'd120, 4'h9, 4'h4}
   };

   rgb_t ref_palette [16] = '{
      12'h000, 12'h000, 12'h2C4, 12'h5D7, 12'h55E, 12'h77F, 12'hD54, 12'h4EF,
      12'hF55, 12'hF77, 12'hDC5, 12'hEC8, 12'h2B3, 12'hC5B, 12'hCCC, 12'hFFF
   };

   logic        clk;
   logic        rst_i;
   logic        vdp_clk_en_i;
   logic        vga_clk_en_i;
   logic        vdp_hsync_i;
   logic [3:0]  vdp_color_i;
   logic [3:0]  overlay_color_i;
   logic        vga_hsync_o;
   logic        vga_de_o;
   logic [3:0]  vga_r_o;
   logic [3:0]  vga_g_o;
   logic [3:0]  vga_b_o;
   rgb_t        rgb_out;
   logic [1:0]  en_phase;
   logic [31:0] lcg_state;
   logic        pre_line;   // No line has finished on the input yet.
   logic        de_seen;
   logic        sync_seen;  // Output sync seen since the last run.
   int          run_pix;
   int          runs_done;
   int          checks;
   int          errors;
   int          timeouts;
   rgb_t        exp_pix [$];
   addr_t       exp_len [$];

   assign rgb_out = {vga_r_o, vga_g_o, vga_b_o};

   video_out_top DUT (
      .clk             (clk),
      .rst_i           (rst_i),
      .vdp_clk_en_i    (vdp_clk_en_i),
      .vga_clk_en_i    (vga_clk_en_i),
      .vdp_hsync_i     (vdp_hsync_i),
      .vdp_color_i     (vdp_color_i),
      .overlay_color_i (overlay_color_i),
      .vga_hsync_o     (vga_hsync_o),
      .vga_de_o        (vga_de_o),
      .vga_r_o         (vga_r_o),
      .vga_g_o         (vga_g_o),
      .vga_b_o         (vga_b_o)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      en_phase     <= en_phase + 2'd1;
      vdp_clk_en_i <= (en_phase == 2'd3);
      vga_clk_en_i <= en_phase[0];
   end

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0d ns: %s expected %h, got %h", $time, what, exp, got);
      end
   endtask

   task automatic check_count(input addr_t got, input addr_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0d ns: %s expected %0d, got %0d", $time, what, exp, got);
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0d ns: %s expected %b, got %b", $time, what, exp, got);
      end
   endtask

   task automatic end_run();
      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   endtask

   // Holds one input value until the writer takes it on an input enable.
   task automatic send_input(input logic sync, input color_t color);
      int waited;
      vdp_hsync_i <= sync;
      vdp_color_i <= color;
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (!vdp_clk_en_i && waited < EN_TIMEOUT);
      if (!vdp_clk_en_i) begin
         timeouts++;
         $display("timeout: no input pixel enable within %0d clocks", EN_TIMEOUT);
      end
   endtask

   task automatic drive_line(input row_t row);
      color_t pix;
      rgb_t   line_rgb [$];
      int     i;
      int     c;
      for (i = 0; i < int'(row.len) && timeouts == 0; i++) begin
         if (i == 0) begin
            pix = row.base;
         end else begin
            lcg_state = next_rand(lcg_state);
            pix       = lcg_state[19:16];  // Color from the upper state bits.
         end
         line_rgb.push_back((row.overlay != 4'h0) ? ref_palette[row.overlay] : ref_palette[pix]);
         send_input(1'b0, pix);
      end
      for (c = 0; c < 2; c++) begin
         exp_len.push_back(row.len);
         for (i = 0; i < line_rgb.size(); i++) begin
            exp_pix.push_back(line_rgb[i]);
         end
      end
      overlay_color_i <= row.overlay;  // Held until this line has been shown twice.
      pre_line = 1'b0;
      for (i = 0; i < HSYNC_WIDTH + 8 && timeouts == 0; i++) begin
         send_input(1'b1, 4'h0);
      end
   endtask

   task automatic wait_runs(input int count);
      int waited;
      waited = 0;
      while (runs_done < count && waited < RUN_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (runs_done < count) begin
         timeouts++;
         $display("timeout: only %0d of %0d output runs seen", runs_done, count);
      end
   endtask

   // One sample per output pixel, taken in the middle of its hold time.
   always @(negedge clk) begin
      if (!rst_i && pre_line) begin
         check_level(vga_de_o, 1'b0, "display enable before first line");
         check_rgb(rgb_out, 12'h000, "rgb before first line");
      end
      if (!rst_i && vga_clk_en_i) begin
         if (vga_hsync_o) begin
            sync_seen = 1'b1;
         end
         if (vga_de_o) begin
            if (!de_seen) begin
               check_level(sync_seen, 1'b1, "hsync pulse before run");
               sync_seen = 1'b0;
            end
            if (exp_pix.size() == 0) begin
               errors++;
               $display("output pixel at %0d ns with no input line pending", $time);
            end else begin
               check_rgb(rgb_out, exp_pix.pop_front(), "pixel");
            end
            run_pix++;
         end else if (de_seen) begin
            if (exp_len.size() == 0) begin
               errors++;
               $display("output run at %0d ns with no input line pending", $time);
            end else begin
               check_count(addr_t'(run_pix), exp_len.pop_front(), "run length");
            end
            run_pix = 0;
            runs_done++;
         end
         de_seen = vga_de_o;
      end
   end

   initial begin
      int r;
      clk             = 1'b0;
      rst_i           = 1'b1;
      vdp_clk_en_i    = 1'b0;
      vga_clk_en_i    = 1'b0;
      vdp_hsync_i     = 1'b1;
      vdp_color_i     = 4'h0;
      overlay_color_i = 4'h0;
      en_phase        = 2'd0;
      lcg_state       = 32'd33303;
      pre_line        = 1'b1;
      de_seen         = 1'b0;
      sync_seen       = 1'b0;
      run_pix         = 0;
      runs_done       = 0;
      checks          = 0;
      errors          = 0;
      timeouts        = 0;
      repeat (2) @(posedge clk);
      rst_i <= 1'b0;
      for (r = 0; r < ROWS && timeouts == 0; r++) begin
         drive_line(stim_table[r]);
      end
      if (timeouts == 0) begin
         wait_runs(2 * ROWS);
      end
      end_run();
   end

endmodule

//--- verification/video_out_properties.sv
`timescale 1ns/1ps

module video_out_properties (
   input logic       clk,
   input logic       rst_i,
   input logic       vga_clk_en_i,
   input logic       hsync_i,
   input logic       de_i,
   input logic [3:0] r_i,
   input logic [3:0] g_i,
   input logic [3:0] b_i
);
   import video_pkg::*;

   int sync_en_cnt;  // Output enables seen in the current sync pulse.

   always_ff @(posedge clk) begin
      if (rst_i || !hsync_i) begin
         sync_en_cnt <= 0;
      end else if (vga_clk_en_i) begin
         sync_en_cnt <= sync_en_cnt + 1;
      end
   end

   sync_de_apart: assert property (@(posedge clk) disable iff (rst_i)
      !(hsync_i && de_i))
      else $error("hsync and display enable high together");

   sync_width: assert property (@(posedge clk) disable iff (rst_i)
      $fell(hsync_i) |-> (sync_en_cnt == HSYNC_WIDTH))
      else $error("hsync pulse lasted %0d output enables", sync_en_cnt);

   blank_rgb: assert property (@(posedge clk) disable iff (rst_i)
      !de_i |-> ({r_i, g_i, b_i} == 12'h000))
      else $error("rgb not blank outside the active area");

   reset_quiet: assert property (@(posedge clk)
      rst_i |=> (!hsync_i && !de_i))
      else $error("outputs active during reset");

endmodule

bind video_out_top video_out_properties u_props (
   .clk          (clk),
   .rst_i        (rst_i),
   .vga_clk_en_i (vga_clk_en_i),
   .hsync_i      (vga_hsync_o),
   .de_i         (vga_de_o),
   .r_i          (vga_r_o),
   .g_i          (vga_g_o),
   .b_i          (vga_b_o)
);

//--- logic/video_out_top.sv
`timescale 1ns/1ps

module video_out_top (
   input  logic       clk,
   input  logic       rst_i,
   input  logic       vdp_clk_en_i,
   input  logic       vga_clk_en_i,
   input  logic       vdp_hsync_i,
   input  logic [3:0] vdp_color_i,
   input  logic [3:0] overlay_color_i,
   output logic       vga_hsync_o,
   output logic       vga_de_o,
   output logic [3:0] vga_r_o,
   output logic [3:0] vga_g_o,
   output logic [3:0] vga_b_o
);
   import video_pkg::*;

   line_wr_if wr_bus ();

   logic   line_done;
   addr_t  line_len;
   bank_t  done_bank;
   addr_t  rd_addr;
   color_t rd_data [NUM_LINE_BUFS];
   logic   dbl_hsync;
   logic   dbl_de;
   color_t dbl_pixel;
   rgb_t   rgb;

   line_writer u_writer (
      .clk          (clk),
      .rst_i        (rst_i),
      .vdp_clk_en_i (vdp_clk_en_i),
      .vdp_hsync_i  (vdp_hsync_i),
      .vdp_color_i  (vdp_color_i),
      .wr           (wr_bus.writer),
      .line_done_o  (line_done),
      .line_len_o   (line_len),
      .done_bank_o  (done_bank)
   );

   for (genvar i = 0; i < NUM_LINE_BUFS; i++) begin : g_buf
      line_buffer #(.BANK_ID(bank_t'(i))) u_buf (
         .clk       (clk),
         .wr        (wr_bus.buffer),
         .rd_addr_i (rd_addr),
         .rd_data_o (rd_data[i])
      );
   end

   line_reader u_reader (
      .clk          (clk),
      .rst_i        (rst_i),
      .vga_clk_en_i (vga_clk_en_i),
      .line_done_i  (line_done),
      .line_len_i   (line_len),
      .done_bank_i  (done_bank),
      .rd_addr_o    (rd_addr),
      .rd_data_i    (rd_data),
      .vga_hsync_o  (dbl_hsync),
      .vga_de_o     (dbl_de),
      .pixel_o      (dbl_pixel)
   );

   rgb_encoder u_encoder (
      .clk             (clk),
      .rst_i           (rst_i),
      .de_i            (dbl_de),
      .hsync_i         (dbl_hsync),
      .pixel_i         (dbl_pixel),
      .overlay_color_i (overlay_color_i),
      .hsync_o         (vga_hsync_o),
      .de_o            (vga_de_o),
      .rgb_o           (rgb)
   );

   assign vga_r_o = rgb.r;
   assign vga_g_o = rgb.g;
   assign vga_b_o = rgb.b;

endmodule

//--- logic/rgb_encoder.sv
`timescale 1ns/1ps

module rgb_encoder (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              de_i,
   input  logic              hsync_i,
   input  video_pkg::color_t pixel_i,
   input  video_pkg::color_t overlay_color_i,
   output logic              hsync_o,
   output logic              de_o,
   output video_pkg::rgb_t   rgb_o
);
   import video_pkg::*;

   color_t mix_color;
   rgb_t   lut_rgb;

   // Overlay color 0 is see-through.
   assign mix_color = (overlay_color_i != '0) ? overlay_color_i : pixel_i;
   assign lut_rgb   = PALETTE[mix_color];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         hsync_o <= 1'b0;
         de_o    <= 1'b0;
         rgb_o   <= '0;
      end else begin
         hsync_o <= hsync_i;
         de_o    <= de_i;
         rgb_o   <= de_i ? lut_rgb : '0;  // Blank outside the active area.
      end
   end

endmodule

//--- logic/line_reader.sv
`timescale 1ns/1ps

module line_reader (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              vga_clk_en_i,
   input  logic              line_done_i,
   input  video_pkg::addr_t  line_len_i,
   input  video_pkg::bank_t  done_bank_i,
   output video_pkg::addr_t  rd_addr_o,
   input  video_pkg::color_t rd_data_i [video_pkg::NUM_LINE_BUFS],
   output logic              vga_hsync_o,
   output logic              vga_de_o,
   output video_pkg::color_t pixel_o
);
   import video_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SYNC,
      ST_ACTIVE
   } state_t;

   state_t    state_q;
   logic      copy_q;  // Second copy of the line when set.
   sync_cnt_t sync_cnt_q;
   addr_t     addr_q;
   addr_t     last_q;
   bank_t     bank_q;
   logic      en_q;
   logic      s1_de_q;
   logic      s1_sync_q;
   color_t    data_q;
   color_t    rd_sel;

   assign rd_addr_o = addr_q;
   assign rd_sel    = rd_data_i[bank_q];

   always_ff @(posedge clk) begin
      if (line_done_i) begin
         last_q <= line_len_i - 1'b1;
         bank_q <= done_bank_i;
      end
   end

   // A new line restarts playback even mid copy.
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q    <= ST_IDLE;
         copy_q     <= 1'b0;
         sync_cnt_q <= '0;
         addr_q     <= '0;
      end else if (line_done_i) begin
         state_q    <= ST_SYNC;
         copy_q     <= 1'b0;
         sync_cnt_q <= '0;
         addr_q     <= '0;
      end else if (vga_clk_en_i) begin
         case (state_q)
            ST_SYNC: begin
               if (sync_cnt_q == SYNC_LAST) begin
                  sync_cnt_q <= '0;
                  state_q    <= ST_ACTIVE;
               end else begin
                  sync_cnt_q <= sync_cnt_q + 1'b1;
               end
            end
            ST_ACTIVE: begin
               if (addr_q == last_q) begin
                  addr_q <= '0;
                  if (copy_q) begin
                     state_q <= ST_IDLE;
                  end else begin
                     copy_q  <= 1'b1;
                     state_q <= ST_SYNC;
                  end
               end else begin
                  addr_q <= addr_q + 1'b1;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Stage 1 marks the fetch, stage 2 emits with the returned pixel.
   always_ff @(posedge clk) begin
      if (rst_i) begin
         en_q        <= 1'b0;
         s1_de_q     <= 1'b0;
         s1_sync_q   <= 1'b0;
         vga_de_o    <= 1'b0;
         vga_hsync_o <= 1'b0;
      end else begin
         en_q <= vga_clk_en_i;
         if (vga_clk_en_i) begin
            s1_de_q     <= (state_q == ST_ACTIVE);
            s1_sync_q   <= (state_q == ST_SYNC);
            vga_de_o    <= s1_de_q;
            vga_hsync_o <= s1_sync_q;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (en_q) begin
         data_q <= rd_sel;  // Read data is only valid the clock after a fetch.
      end
      if (vga_clk_en_i) begin
         pixel_o <= en_q ? rd_sel : data_q;  // Back to back enables bypass the hold.
      end
   end

endmodule

//--- logic/line_writer.sv
`timescale 1ns/1ps

module line_writer (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              vdp_clk_en_i,
   input  logic              vdp_hsync_i,
   input  video_pkg::color_t vdp_color_i,
   line_wr_if.writer         wr,
   output logic              line_done_o,
   output video_pkg::addr_t  line_len_o,
   output video_pkg::bank_t  done_bank_o
);
   import video_pkg::*;

   logic  sync_q;
   addr_t pix_cnt_q;
   bank_t bank_q;
   logic  line_full;
   logic  sync_rise;
   bank_t bank_next;

   assign line_full = (pix_cnt_q == MAX_LINE_LEN);  // Saturate, drop the rest.

   // Sync is only looked at on pixel enables.
   assign sync_rise = vdp_clk_en_i && vdp_hsync_i && !sync_q;

   assign bank_next = (bank_q == bank_t'(NUM_LINE_BUFS - 1)) ? '0 : bank_q + 1'b1;

   assign wr.wr_en   = vdp_clk_en_i && !vdp_hsync_i && !line_full;
   assign wr.wr_bank = bank_q;
   assign wr.wr_addr = pix_cnt_q;
   assign wr.wr_data = vdp_color_i;

   assign line_done_o = sync_rise;
   assign line_len_o  = pix_cnt_q;
   assign done_bank_o = bank_q;  // Still the finished bank in the done cycle.

   always_ff @(posedge clk) begin
      if (rst_i) begin
         sync_q    <= 1'b1;  // No line done until a low period is seen.
         pix_cnt_q <= '0;
         bank_q    <= '0;
      end else if (vdp_clk_en_i) begin
         sync_q <= vdp_hsync_i;
         if (sync_rise) begin
            pix_cnt_q <= '0;
            bank_q    <= bank_next;
         end else if (wr.wr_en) begin
            pix_cnt_q <= pix_cnt_q + 1'b1;
         end
      end
   end

endmodule

//--- logic/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
   parameter video_pkg::bank_t BANK_ID = '0
) (
   input  logic              clk,
   line_wr_if.buffer         wr,
   input  video_pkg::addr_t  rd_addr_i,
   output video_pkg::color_t rd_data_o
);
   import video_pkg::*;

   color_t mem [LINE_PIXELS];
   logic   bank_hit;

   // Write side is broadcast, each buffer picks out its own bank.
   assign bank_hit = (wr.wr_bank == BANK_ID);

   always_ff @(posedge clk) begin
      if (wr.wr_en && bank_hit) begin
         mem[wr.wr_addr] <= wr.wr_data;
      end
   end

   always_ff @(posedge clk) begin
      rd_data_o <= mem[rd_addr_i];  // One clock read latency.
   end

endmodule

//--- logic/line_wr_if.sv
`timescale 1ns/1ps

interface line_wr_if;
   import video_pkg::*;

   logic   wr_en;
   bank_t  wr_bank;
   addr_t  wr_addr;
   color_t wr_data;

   modport writer (
      output wr_en,
      output wr_bank,
      output wr_addr,
      output wr_data
   );

   modport buffer (
      input wr_en,
      input wr_bank,
      input wr_addr,
      input wr_data
   );

endinterface

//--- logic/video_pkg.sv
package video_pkg;

   localparam int LINE_PIXELS   = 512;
   localparam int NUM_LINE_BUFS = 2;
   localparam int HSYNC_WIDTH   = 32;  // Counted in output enables.

   typedef logic [3:0] color_t;
   typedef logic [$clog2(LINE_PIXELS)-1:0] addr_t;
   typedef logic [$clog2(NUM_LINE_BUFS)-1:0] bank_t;
   typedef logic [$clog2(HSYNC_WIDTH)-1:0] sync_cnt_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb_t;

   localparam addr_t     MAX_LINE_LEN = addr_t'(LINE_PIXELS - 1);
   localparam sync_cnt_t SYNC_LAST    = sync_cnt_t'(HSYNC_WIDTH - 1);

   // VDP standard colors, one nibble per channel.
   localparam rgb_t PALETTE [16] = '{
      12'h000,  // Transparent.
      12'h000,  // Black.
      12'h2C4,  // Medium green.
      12'h5D7,  // Light green.
      12'h55E,  // Dark blue.
      12'h77F,  // Light blue.
      12'hD54,  // Dark red.
      12'h4EF,  // Cyan.
      12'hF55,  // Medium red.
      12'hF77,  // Light red.
      12'hDC5,  // Dark yellow.
      12'hEC8,  // Light yellow.
      12'h2B3,  // Dark green.
      12'hC5B,  // Magenta.
      12'hCCC,  // Gray.
      12'hFFF   // White.
   };

endpackage
